/* verilog.f */
+incdir+verilog
verilog/hc_pkg.sv
verilog/hc_csr_decode.sv
verilog/hc_test_engine.sv
verilog/hc_test_status.sv
verilog/hc_top.sv
sim/hc_top_asserts.sv
sim/hc_top_tb.sv

/* Makefile */
# Verilator build and run of the host channel testbench
# Any variable can be overridden from the command line, e.g. make LOG=run1.log

VERILATOR   ?= verilator
TOP         ?= hc_top_tb
FILELIST    ?= verilog.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
FAIL_MSG    ?= test failed
PASS_MSG    ?= test passed

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, so a failing run shows up even if the simulator exits with 0
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/hc_top_tb.sv */
`timescale 1ns/1ps

`include "hc_cfg.svh"

module hc_top_tb;

    import hc_pkg::*;

    localparam int NROWS = 7;

    // One test per row, programmed through host writes and then checked
    typedef struct packed
    {
        logic [31:0]  en;
        t_line_addr   ctrl;
        logic         ctrl_full;
        t_line_addr   rd;
        t_line_addr   wr;
        t_enable_test cmd;
        logic         second;
        logic         has_status;
        t_line_count  exp_reads;
        t_line_count  exp_writes;
        t_line_data   exp_sum;
    } t_row;

    t_row rows [NROWS];

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic mmio_wr_valid = 1'b0;
    t_mmio_addr mmio_wr_addr = '0;
    t_mmio_data mmio_wr_data = '0;
    logic mem_req_ready = 1'b0;
    logic mem_rsp_valid = 1'b0;
    logic mem_rsp_write = 1'b0;
    t_line_data mem_rsp_data = '0;

    logic mem_req_valid;
    logic mem_req_write;
    t_line_addr mem_req_addr;
    t_line_data mem_req_data;
    logic mem_req_user;
    logic status_valid;
    t_line_addr status_addr;
    t_line_count status_reads;
    t_line_count status_writes;
    t_line_data status_checksum;

    integer seed = 32'hda3c_c0c9;

    // The main process sets the context of the current row at a falling edge
    logic [31:0] cur_en;
    logic cur_run;
    t_line_addr cur_ctrl;
    t_line_addr cur_rd;
    t_line_addr cur_wr;
    t_line_count cur_reads;
    t_line_count cur_writes;
    t_line_data cur_sum;

    // Totals kept by the monitors and the marks taken at the start of each row
    int rd_total = 0;
    int wr_total = 0;
    int stat_total = 0;
    int rd_mark = 0;
    int wr_mark = 0;
    int stat_mark = 0;

    // Responses waiting in the memory model
    int cycle = 0;
    int pend_due[$];
    logic pend_write[$];
    t_line_data pend_data[$];

    hc_top uut (
        .clk             (clk),
        .reset           (reset),
        .mmio_wr_valid   (mmio_wr_valid),
        .mmio_wr_addr    (mmio_wr_addr),
        .mmio_wr_data    (mmio_wr_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_write   (mem_req_write),
        .mem_req_addr    (mem_req_addr),
        .mem_req_data    (mem_req_data),
        .mem_req_user    (mem_req_user),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_write   (mem_rsp_write),
        .mem_rsp_data    (mem_rsp_data),
        .status_valid    (status_valid),
        .status_addr     (status_addr),
        .status_reads    (status_reads),
        .status_writes   (status_writes),
        .status_checksum (status_checksum)
    );

    always #4 clk = ~clk;

    task automatic end_failed();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, want);
        end_failed();
    endtask

    task automatic report_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        end_failed();
    endtask

    // A line reads as its address times 3 plus 1
    function automatic t_line_data line_read_data(input t_line_addr addr);
        return t_line_data'(addr * t_line_addr'(3) + t_line_addr'(1));
    endfunction

    // Checksums follow the memory rule
    // Row 0 sums 0x3001, 0x3004, 0x3007 and 0x300a
    // Row 2 frames need both halves, and its read lines wrap to 0x21 + 3i
    task automatic fill_table();
        rows[0] = '{32'h1, 42'h100, 1'b1, 42'h1000, 42'h2000,
                    16'h0401, 1'b0, 1'b1, 8'd4, 8'd0, 32'h0000_c016};
        rows[1] = '{32'h3, 42'h200, 1'b1, 42'h1000, 42'h3000,
                    16'h0502, 1'b0, 1'b1, 8'd0, 8'd5, 32'h0000_0000};
        rows[2] = '{32'h1, 42'h2_0000_0300, 1'b1, 42'h1_5555_5560, 42'h3_0000_0000,
                    16'h0603, 1'b0, 1'b1, 8'd6, 8'd6, 32'h0000_00f3};
        // Status frame left with only its high half, so the start is dropped
        rows[3] = '{32'h1, 42'h400, 1'b0, 42'h1000, 42'h2000,
                    16'h0203, 1'b0, 1'b0, 8'd0, 8'd0, 32'h0000_0000};
        // Channel disabled
        rows[4] = '{32'h0, 42'h500, 1'b1, 42'h1000, 42'h2000,
                    16'h0201, 1'b0, 1'b0, 8'd0, 8'd0, 32'h0000_0000};
        // Zero line count
        rows[5] = '{32'h1, 42'h600, 1'b1, 42'h1000, 42'h2000,
                    16'h0003, 1'b0, 1'b0, 8'd0, 8'd0, 32'h0000_0000};
        // A second start right behind the first one must be ignored
        rows[6] = '{32'h1, 42'h700, 1'b1, 42'h8000, 42'h9000,
                    16'h0301, 1'b1, 1'b1, 8'd3, 8'd0, 32'h0004_800c};
    endtask

    // One host write per cycle to the register at the given byte offset
    task automatic host_write(input int offset, input t_mmio_data data);
        @(posedge clk);
        mmio_wr_valid <= 1'b1;
        mmio_wr_addr <= t_mmio_addr'((`HC_CSR_BASE_ADDR + offset) >> 2);
        mmio_wr_data <= data;
    endtask

    task automatic host_release();
        @(posedge clk);
        mmio_wr_valid <= 1'b0;
    endtask

    task automatic run_row(input int r);
        t_row row;
        row = rows[r];
        @(negedge clk);
        cur_en = row.en;
        cur_run = row.has_status;
        cur_ctrl = row.ctrl;
        cur_rd = row.rd;
        cur_wr = row.wr;
        cur_reads = row.exp_reads;
        cur_writes = row.exp_writes;
        cur_sum = row.exp_sum;
        rd_mark = rd_total;
        wr_mark = wr_total;
        stat_mark = stat_total;

        // Each 64-bit frame goes high half first at the odd word, then the low half
        host_write(`HC_CSR_EN, row.en);
        host_write(`HC_CSR_CTRL_FRAME + 4, t_mmio_data'(row.ctrl >> 32));
        if (row.ctrl_full)
        begin
            host_write(`HC_CSR_CTRL_FRAME, row.ctrl[31:0]);
        end
        host_write(`HC_CSR_READ_FRAME + 4, t_mmio_data'(row.rd >> 32));
        host_write(`HC_CSR_READ_FRAME, row.rd[31:0]);
        host_write(`HC_CSR_WRITE_FRAME + 4, t_mmio_data'(row.wr >> 32));
        host_write(`HC_CSR_WRITE_FRAME, row.wr[31:0]);
        host_write(`HC_CSR_ENABLE_TEST, t_mmio_data'(row.cmd));
        if (row.second)
        begin
            // This asks for four writes and would break the expected request order if taken
            host_write(`HC_CSR_ENABLE_TEST, 32'h0000_0402);
        end
        host_release();

        // Wait for the status record of a run that should produce one
        if (row.has_status)
        begin
            while (stat_total == stat_mark)
            begin
                @(posedge clk);
            end
        end
        // Quiet time for late responses and for requests that must not appear
        repeat (30) @(posedge clk);

        assert (rd_total - rd_mark == int'(row.exp_reads))
            else report_mismatch("read requests", 64'(rd_total - rd_mark), 64'(row.exp_reads));
        assert (wr_total - wr_mark == int'(row.exp_writes))
            else report_mismatch("write requests", 64'(wr_total - wr_mark), 64'(row.exp_writes));
        assert (stat_total - stat_mark == int'(row.has_status))
            else report_mismatch("status records", 64'(stat_total - stat_mark),
                                 64'(row.has_status));
    endtask

    // Checks one transferred request against the frames and order of the run
    task automatic check_request();
        int rd_idx;
        int wr_idx;
        t_line_addr want_addr;
        rd_idx = rd_total - rd_mark;
        wr_idx = wr_total - wr_mark;
        assert (cur_run)
            else report_error("memory request issued for a command that should be dropped");
        assert (mem_req_user == cur_en[1])
            else report_mismatch("mem_req_user", 64'(mem_req_user), 64'(cur_en[1]));
        if (!mem_req_write)
        begin
            want_addr = cur_rd + t_line_addr'(rd_idx);
            assert (wr_idx == 0)
                else report_error("read request issued after a write request");
            assert (rd_idx < int'(cur_reads))
                else report_error("more read requests than the command asked for");
            assert (mem_req_addr == want_addr)
                else report_mismatch("mem_req_addr", 64'(mem_req_addr), 64'(want_addr));
            rd_total <= rd_total + 1;
        end
        else
        begin
            want_addr = cur_wr + t_line_addr'(wr_idx);
            assert (rd_idx == int'(cur_reads))
                else report_error("write request issued before all reads");
            assert (wr_idx < int'(cur_writes))
                else report_error("more write requests than the command asked for");
            assert (mem_req_addr == want_addr)
                else report_mismatch("mem_req_addr", 64'(mem_req_addr), 64'(want_addr));
            assert (mem_req_data == t_line_data'(wr_idx))
                else report_mismatch("mem_req_data", 64'(mem_req_data), 64'(wr_idx));
            wr_total <= wr_total + 1;
        end
    endtask

    // Memory model with random ready and responses 1 to 6 cycles after each request
    // Responses go out whenever they fall due, so their order is mixed
    always @(posedge clk)
    begin
        int delay;
        int pick;
        cycle = cycle + 1;
        if (reset)
        begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end
        else
        begin
            mem_req_ready <= ($random(seed) & 3) != 0;
            if (mem_req_valid && mem_req_ready)
            begin
                check_request();
                delay = 1 + int'($unsigned($random(seed)) % 6);
                pend_due.push_back(cycle + delay);
                pend_write.push_back(mem_req_write);
                pend_data.push_back(mem_req_write ? '0 : line_read_data(mem_req_addr));
            end
            pick = -1;
            foreach (pend_due[i])
            begin
                if (pick < 0 && pend_due[i] <= cycle)
                begin
                    pick = i;
                end
            end
            if (pick >= 0)
            begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_write <= pend_write[pick];
                mem_rsp_data <= pend_data[pick];
                pend_due.delete(pick);
                pend_write.delete(pick);
                pend_data.delete(pick);
            end
            else
            begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    // Status record monitor
    always @(posedge clk)
    begin
        if (!reset && status_valid)
        begin
            assert (cur_run)
                else report_error("status record produced for a command that should be dropped");
            assert (stat_total == stat_mark)
                else report_error("more than one status record for one run");
            assert (status_addr == cur_ctrl)
                else report_mismatch("status_addr", 64'(status_addr), 64'(cur_ctrl));
            assert (status_reads == cur_reads)
                else report_mismatch("status_reads", 64'(status_reads), 64'(cur_reads));
            assert (status_writes == cur_writes)
                else report_mismatch("status_writes", 64'(status_writes), 64'(cur_writes));
            assert (status_checksum == cur_sum)
                else report_mismatch("status_checksum", 64'(status_checksum), 64'(cur_sum));
            stat_total <= stat_total + 1;
        end
    end

    // Watchdog sized from the table with 200 cycles per row and 20 per line
    initial
    begin
        int limit;
        #1;
        limit = 200 * NROWS;
        for (int i = 0; i < NROWS; i++)
        begin
            limit = limit + 20 * int'(rows[i].cmd[15:8]);
        end
        repeat (limit) @(posedge clk);
        report_error("watchdog expired before all table rows were done");
    end

    initial
    begin
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NROWS; r++)
        begin
            run_row(r);
        end
        $display("test passed");
        $finish;
    end

endmodule

/* sim/hc_top_asserts.sv */
`timescale 1ns/1ps

// Protocol checks on the memory request port and the status record
// Bound into hc_top so that internal handshakes can be watched too
module hc_top_asserts
(
    input logic               clk,
    input logic               reset,
    input logic               mem_req_valid,
    input logic               mem_req_ready,
    input logic               mem_req_write,
    input hc_pkg::t_line_addr mem_req_addr,
    input hc_pkg::t_line_data mem_req_data,
    input logic               mem_req_user,
    input logic               test_start,
    input logic               status_valid
);

    // A stalled request keeps valid and its whole payload until it transfers
    property req_held_while_stalled;
        @(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=>
            (mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr) &&
             $stable(mem_req_data) && $stable(mem_req_user));
    endproperty

    // Outputs that start activity are cleared by reset
    property quiet_after_reset;
        @(posedge clk)
        reset |=> (!mem_req_valid && !status_valid && !test_start);
    endproperty

    // The status record is a single-cycle pulse
    property status_single_cycle;
        @(posedge clk) disable iff (reset)
        status_valid |=> !status_valid;
    endproperty

    assert property (req_held_while_stalled)
        else $error("memory request changed or dropped while ready was low");
    assert property (quiet_after_reset)
        else $error("request, start or status active right after reset");
    assert property (status_single_cycle)
        else $error("status_valid held for more than one cycle");

endmodule

bind hc_top hc_top_asserts u_asserts (.*);

/* verilog/hc_top.sv */
`timescale 1ns/1ps

`include "hc_cfg.svh"

// Host channel control block
// Host register writes program the decoder, the engine issues the memory
// traffic and the collector reports the result of each run
// A write to the test register shows its first request 2 cycles later
module hc_top
#(
    parameter int CSR_BASE_ADDR = `HC_CSR_BASE_ADDR
)
(
    input  logic                clk,
    input  logic                reset,

    // Host write channel
    input  logic                mmio_wr_valid,
    input  hc_pkg::t_mmio_addr  mmio_wr_addr,
    input  hc_pkg::t_mmio_data  mmio_wr_data,

    // Memory request channel
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output logic                mem_req_write,
    output hc_pkg::t_line_addr  mem_req_addr,
    output hc_pkg::t_line_data  mem_req_data,
    output logic                mem_req_user,

    // Memory response channel
    input  logic                mem_rsp_valid,
    input  logic                mem_rsp_write,
    input  hc_pkg::t_line_data  mem_rsp_data,

    // Status record of a finished run
    output logic                status_valid,
    output hc_pkg::t_line_addr  status_addr,
    output hc_pkg::t_line_count status_reads,
    output hc_pkg::t_line_count status_writes,
    output hc_pkg::t_line_data  status_checksum
);

    import hc_pkg::*;

    // Decoder to engine
    logic hc_en;
    logic hc_en_user_channel;
    t_line_addr ctrl_frame;
    logic ctrl_frame_valid;
    t_line_addr read_frame;
    t_line_addr write_frame;
    t_enable_test enable_test;

    // Engine and collector handshake
    logic status_busy;
    logic test_start;
    t_line_count exp_reads;
    t_line_count exp_writes;

    hc_csr_decode #(
        .CSR_BASE_ADDR (CSR_BASE_ADDR)
    ) u_csr_decode (
        .clk                (clk),
        .reset              (reset),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_wr_addr       (mmio_wr_addr),
        .mmio_wr_data       (mmio_wr_data),
        .hc_en              (hc_en),
        .hc_en_user_channel (hc_en_user_channel),
        .ctrl_frame         (ctrl_frame),
        .ctrl_frame_valid   (ctrl_frame_valid),
        .read_frame         (read_frame),
        .write_frame        (write_frame),
        .enable_test        (enable_test)
    );

    hc_test_engine u_test_engine (
        .clk                (clk),
        .reset              (reset),
        .hc_en              (hc_en),
        .hc_en_user_channel (hc_en_user_channel),
        .ctrl_frame_valid   (ctrl_frame_valid),
        .read_frame         (read_frame),
        .write_frame        (write_frame),
        .enable_test        (enable_test),
        .mem_req_valid      (mem_req_valid),
        .mem_req_ready      (mem_req_ready),
        .mem_req_write      (mem_req_write),
        .mem_req_addr       (mem_req_addr),
        .mem_req_data       (mem_req_data),
        .mem_req_user       (mem_req_user),
        .status_busy        (status_busy),
        .test_start         (test_start),
        .exp_reads          (exp_reads),
        .exp_writes         (exp_writes)
    );

    hc_test_status u_test_status (
        .clk             (clk),
        .reset           (reset),
        .test_start      (test_start),
        .exp_reads       (exp_reads),
        .exp_writes      (exp_writes),
        .ctrl_frame      (ctrl_frame),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_write   (mem_rsp_write),
        .mem_rsp_data    (mem_rsp_data),
        .status_busy     (status_busy),
        .status_valid    (status_valid),
        .status_addr     (status_addr),
        .status_reads    (status_reads),
        .status_writes   (status_writes),
        .status_checksum (status_checksum)
    );

endmodule

/* verilog/hc_test_status.sv */
`timescale 1ns/1ps

// Result stage of the traffic test
// Counts the responses of one run, sums the read data and reports
// a single status record once both expected counts are reached
module hc_test_status
(
    input  logic                clk,
    input  logic                reset,

    // Run start from the test engine
    input  logic                test_start,
    input  hc_pkg::t_line_count exp_reads,
    input  hc_pkg::t_line_count exp_writes,
    input  hc_pkg::t_line_addr  ctrl_frame,

    // Memory response channel with responses in any order
    input  logic                mem_rsp_valid,
    input  logic                mem_rsp_write,
    input  hc_pkg::t_line_data  mem_rsp_data,

    // Status record
    output logic                status_busy,
    output logic                status_valid,
    output hc_pkg::t_line_addr  status_addr,
    output hc_pkg::t_line_count status_reads,
    output hc_pkg::t_line_count status_writes,
    output hc_pkg::t_line_data  status_checksum
);

    import hc_pkg::*;

    // Targets latched at start
    t_line_count want_reads;
    t_line_count want_writes;

    // Counts including the response in this cycle
    t_line_count next_reads;
    t_line_count next_writes;
    logic rsp_taken;
    logic run_done;

    always_comb
    begin
        // Responses outside a run are dropped
        rsp_taken = status_busy && mem_rsp_valid;
        next_reads = status_reads + t_line_count'(rsp_taken && !mem_rsp_write);
        next_writes = status_writes + t_line_count'(rsp_taken && mem_rsp_write);
        run_done = rsp_taken && (next_reads == want_reads) && (next_writes == want_writes);
    end

    // The engine only starts while busy is low, so test_start is never
    // seen in the middle of a run
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status_busy <= 1'b0;
            status_valid <= 1'b0;
        end
        else
        begin
            status_valid <= run_done;
            if (test_start)
                status_busy <= 1'b1;
            else if (run_done)
                status_busy <= 1'b0;
        end
    end

    // The running counts and the sum are themselves the status record
    always_ff @(posedge clk)
    begin
        if (test_start)
        begin
            want_reads <= exp_reads;
            want_writes <= exp_writes;
            status_addr <= ctrl_frame;
            status_reads <= '0;
            status_writes <= '0;
            status_checksum <= '0;
        end
        else if (rsp_taken)
        begin
            status_reads <= next_reads;
            status_writes <= next_writes;
            // Sum wraps modulo 2^32
            if (!mem_rsp_write)
                status_checksum <= status_checksum + mem_rsp_data;
        end
    end

endmodule

/* verilog/hc_test_engine.sv */
`timescale 1ns/1ps

// Execute stage of the traffic test
// A start command becomes a run of line requests on the memory port
// Reads go to read_frame plus index and writes to write_frame plus index
module hc_test_engine
(
    input  logic                 clk,
    input  logic                 reset,

    // Control state from the register decoder
    input  logic                 hc_en,
    input  logic                 hc_en_user_channel,
    input  logic                 ctrl_frame_valid,
    input  hc_pkg::t_line_addr   read_frame,
    input  hc_pkg::t_line_addr   write_frame,
    input  hc_pkg::t_enable_test enable_test,

    // Memory request port
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output logic                 mem_req_write,
    output hc_pkg::t_line_addr   mem_req_addr,
    output hc_pkg::t_line_data   mem_req_data,
    output logic                 mem_req_user,

    // Handshake with the status collector
    input  logic                 status_busy,
    output logic                 test_start,
    output hc_pkg::t_line_count  exp_reads,
    output hc_pkg::t_line_count  exp_writes
);

    import hc_pkg::*;

    t_engine_state state;

    // Command and bases captured at start
    t_line_count run_count;
    logic run_writes;
    t_line_addr rd_base;
    t_line_addr wr_base;

    // Index of the line on the port within the current phase
    t_line_count line_idx;
    t_line_count next_idx;

    // Fields of the incoming command
    logic cmd_reads;
    logic cmd_writes;
    t_line_count cmd_count;

    logic start_accept;
    logic xfer;
    logic last_line;

    always_comb
    begin
        cmd_reads = enable_test[0];
        cmd_writes = enable_test[1];
        cmd_count = enable_test[15:8];

        // A command is dropped unless the channel is enabled and the status
        // frame is complete, the engine and the collector are both idle,
        // and the command asks for at least one line of some kind
        start_accept = (enable_test != '0) && hc_en && ctrl_frame_valid &&
                       (state == IDLE) && !status_busy &&
                       (cmd_count != '0) && (cmd_reads || cmd_writes);

        xfer = mem_req_valid && mem_req_ready;
        last_line = (line_idx == run_count - 1'b1);
        next_idx = line_idx + 1'b1;
    end

    // Phase sequencing
    // Once started, a run finishes even if hc_en drops, since it is only
    // sampled at start
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            mem_req_valid <= 1'b0;
            test_start <= 1'b0;
        end
        else
        begin
            test_start <= start_accept;
            case (state)
                IDLE:
                begin
                    if (start_accept)
                    begin
                        state <= cmd_reads ? READS : WRITES;
                        mem_req_valid <= 1'b1;
                    end
                end
                READS:
                begin
                    // Writes follow straight on without a gap on the port
                    if (xfer && last_line)
                    begin
                        if (run_writes)
                        begin
                            state <= WRITES;
                        end
                        else
                        begin
                            state <= IDLE;
                            mem_req_valid <= 1'b0;
                        end
                    end
                end
                WRITES:
                begin
                    if (xfer && last_line)
                    begin
                        state <= IDLE;
                        mem_req_valid <= 1'b0;
                    end
                end
                default:
                begin
                    state <= IDLE;
                    mem_req_valid <= 1'b0;
                end
            endcase
        end
    end

    // Request payload only moves after a transfer, so it holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (start_accept)
        begin
            run_count <= cmd_count;
            run_writes <= cmd_writes;
            rd_base <= read_frame;
            wr_base <= write_frame;
            line_idx <= '0;
            mem_req_write <= !cmd_reads;
            mem_req_addr <= cmd_reads ? read_frame : write_frame;
            mem_req_data <= '0;
            mem_req_user <= hc_en_user_channel;
            exp_reads <= cmd_reads ? cmd_count : '0;
            exp_writes <= cmd_writes ? cmd_count : '0;
        end
        else if (xfer && !last_line)
        begin
            line_idx <= next_idx;
            mem_req_addr <= ((state == WRITES) ? wr_base : rd_base) + t_line_addr'(next_idx);
            mem_req_data <= t_line_data'(next_idx);
        end
        else if (xfer && (state == READS))
        begin
            // Last read went out, so line 0 of the write phase is next
            line_idx <= '0;
            mem_req_write <= 1'b1;
            mem_req_addr <= wr_base;
            mem_req_data <= '0;
        end
    end

endmodule

/* verilog/hc_csr_decode.sv */
`timescale 1ns/1ps

`include "hc_cfg.svh"

// Turns host register writes into the control state of the host channel
// Every output is a register and follows its write by one cycle
module hc_csr_decode
#(
    parameter int CSR_BASE_ADDR = `HC_CSR_BASE_ADDR
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Host write channel with no stall
    input  logic                 mmio_wr_valid,
    input  hc_pkg::t_mmio_addr   mmio_wr_addr,
    input  hc_pkg::t_mmio_data   mmio_wr_data,

    // Decoded control state
    output logic                 hc_en,
    output logic                 hc_en_user_channel,
    output hc_pkg::t_line_addr   ctrl_frame,
    output logic                 ctrl_frame_valid,
    output hc_pkg::t_line_addr   read_frame,
    output hc_pkg::t_line_addr   write_frame,
    output hc_pkg::t_enable_test enable_test
);

    import hc_pkg::*;

    localparam int LINE_W = $bits(t_line_addr);
    localparam int WORD_W = $bits(t_mmio_data);

    // Match a 32-bit register
    // The host address counts words, so the byte address drops its low 2 bits
    function automatic logic match32(input int offset);
        t_mmio_addr tgt;
        tgt = t_mmio_addr'((CSR_BASE_ADDR + offset) >> 2);
        return mmio_wr_valid && (mmio_wr_addr == tgt);
    endfunction

    // Match either half of a 64-bit register
    // Address bit 0 picks the half and is ignored in the compare
    function automatic logic match64(input int offset);
        t_mmio_addr tgt;
        t_mmio_addr addr;
        tgt = t_mmio_addr'((CSR_BASE_ADDR + offset) >> 2);
        addr = mmio_wr_addr;
        addr[0] = 1'b0;
        return mmio_wr_valid && (addr == tgt);
    endfunction

    // Shift one 32-bit half into the low end of a frame address
    // After the high and then the low half the frame holds the full address
    function automatic t_line_addr shift_in(input t_line_addr cur, input t_mmio_data word);
        return {cur[LINE_W-WORD_W-1:0], word};
    endfunction

    // Enable word
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hc_en <= 1'b0;
            hc_en_user_channel <= 1'b0;
        end
        else if (match32(`HC_CSR_EN))
        begin
            hc_en <= mmio_wr_data[0];
            hc_en_user_channel <= mmio_wr_data[1];
        end
    end

    // Status frame and its valid flag
    // The high half sits at the odd word and clears the flag
    // The low half comes second at the even word and completes the address
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl_frame_valid <= 1'b0;
        end
        else if (match64(`HC_CSR_CTRL_FRAME))
        begin
            ctrl_frame_valid <= ~mmio_wr_addr[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (match64(`HC_CSR_CTRL_FRAME))
        begin
            ctrl_frame <= shift_in(ctrl_frame, mmio_wr_data);
        end
        // Read and write bases carry no valid flag
        if (match64(`HC_CSR_READ_FRAME))
        begin
            read_frame <= shift_in(read_frame, mmio_wr_data);
        end
        if (match64(`HC_CSR_WRITE_FRAME))
        begin
            write_frame <= shift_in(write_frame, mmio_wr_data);
        end
    end

    // Test command lasts a single cycle and is zero otherwise
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable_test <= '0;
        end
        else if (match32(`HC_CSR_ENABLE_TEST))
        begin
            enable_test <= mmio_wr_data[$bits(t_enable_test)-1:0];
        end
        else
        begin
            enable_test <= '0;
        end
    end

endmodule

/* verilog/hc_pkg.sv */
`include "hc_cfg.svh"

package hc_pkg;

    // Host word address and one host write word
    typedef logic [`HC_MMIO_ADDR_W-1:0] t_mmio_addr;
    typedef logic [`HC_MMIO_DATA_W-1:0] t_mmio_data;

    // Cache-line address and the data word that travels with it
    typedef logic [`HC_LINE_ADDR_W-1:0] t_line_addr;
    typedef logic [`HC_LINE_DATA_W-1:0] t_line_data;

    // Number of lines in a run, or the index of one line within it
    typedef logic [`HC_COUNT_W-1:0] t_line_count;

    // Test command
    // Bit 0 asks for a read phase and bit 1 for a write phase
    // Bits 15:8 give the number of lines in each requested phase
    typedef logic [`HC_ENABLE_TEST_W-1:0] t_enable_test;

    // Test engine state
    // The read phase always runs to completion before the write phase
    typedef enum logic [1:0]
    {
        IDLE,
        READS,
        WRITES
    } t_engine_state;

endpackage

/* verilog/hc_cfg.svh */
`ifndef HC_CFG_SVH
`define HC_CFG_SVH

// Byte base address of the host channel register block
`define HC_CSR_BASE_ADDR 32'h0000_0000

// Register byte offsets from the base address
// Enable word with bit 0 as the channel enable and bit 1 as the user bit
`define HC_CSR_EN 32'h00
// 64-bit status frame address, written high half first
`define HC_CSR_CTRL_FRAME 32'h08
// 64-bit base line address for the read phase
`define HC_CSR_READ_FRAME 32'h10
// 64-bit base line address for the write phase
`define HC_CSR_WRITE_FRAME 32'h18
// Test command register, which holds its value for one cycle only
`define HC_CSR_ENABLE_TEST 32'h20

// Host address width; the host address counts 4-byte words
`define HC_MMIO_ADDR_W 16
// Width of one host write word
`define HC_MMIO_DATA_W 32
// Cache-line address width
`define HC_LINE_ADDR_W 42
// Data word carried with each line in this model
`define HC_LINE_DATA_W 32
// Line count width, which sets the longest test run
`define HC_COUNT_W 8
// Test command width
`define HC_ENABLE_TEST_W 16

`endif
